// ==== Bender.yml ====
package:
  name: lsu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/lsu_pkg.sv
      - src/membus_pkg.sv
      - src/pipe_reg.sv
      - src/mem_access.sv
      - src/byte_ram.sv
      - src/lsu_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - verification/lsu_tb.sv

// ==== include/lsu_defs.svh ====
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// register data width
`define LSU_XLEN 32

// byte address width
`define LSU_ADDR_W 16

// one memory byte
`define LSU_BYTE_W 8

// full address space, wraps at the top
`define LSU_MEM_DEPTH (1 << `LSU_ADDR_W)

`endif

// ==== src/byte_ram.sv ====
`include "lsu_defs.svh"

module byte_ram (
    input  logic                     clk,
    input  membus_pkg::mem_bus_req_t req_i,
    output logic [`LSU_BYTE_W-1:0]   rdata_o
);

    logic [`LSU_BYTE_W-1:0] mem_q [`LSU_MEM_DEPTH];

    // single port, write or registered read
    always_ff @(posedge clk) begin
        if (req_i.en) begin
            if (req_i.we) begin
                mem_q[req_i.addr] <= req_i.wdata;
            end else begin
                rdata_o <= mem_q[req_i.addr];
            end
        end
    end

endmodule

// ==== src/lsu_pkg.sv ====
`include "lsu_defs.svh"

package lsu_pkg;

    // bytes per access
    typedef enum logic [1:0] {
        width_byte = 2'd0, // 1 byte
        width_half = 2'd1, // 2 bytes
        width_word = 2'd2  // 4 bytes
    } mem_width_e;

    // from execute
    typedef struct packed {
        logic [`LSU_XLEN-1:0]   wdata;       // alu value or store data
        logic [`LSU_ADDR_W-1:0] addr;
        logic [4:0]             rd;
        logic                   wreg;
        logic                   is_mem;      // load or store
        logic                   is_store;
        mem_width_e             width;
        logic                   load_signed;
    } ex_result_t;

    // to writeback
    typedef struct packed {
        logic [4:0]           rd;
        logic [`LSU_XLEN-1:0] wdata;
        logic                 wreg;
    } wb_result_t;

endpackage

// ==== src/lsu_top.sv ====
`include "lsu_defs.svh"

module lsu_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid_i,
    output logic                in_ready_o,
    input  lsu_pkg::ex_result_t in_data_i,
    output logic                out_valid_o,
    input  logic                out_ready_i,
    output lsu_pkg::wb_result_t out_data_o
);

    import lsu_pkg::*;
    import membus_pkg::*;

    logic                   ma_in_valid;
    logic                   ma_in_ready;
    ex_result_t             ma_in_data;
    logic                   ma_out_valid;
    logic                   ma_out_ready;
    wb_result_t             ma_out_data;
    mem_bus_req_t           mem_req;
    logic [`LSU_BYTE_W-1:0] mem_rdata;

    pipe_reg #(.payload_t(ex_result_t)) u_in_reg (
        .clk        (clk),
        .rst        (rst),
        .in_valid_i (in_valid_i),
        .in_ready_o (in_ready_o),
        .in_data_i  (in_data_i),
        .out_valid_o(ma_in_valid),
        .out_ready_i(ma_in_ready),
        .out_data_o (ma_in_data)
    );

    mem_access u_mem_access (
        .clk        (clk),
        .rst        (rst),
        .in_valid_i (ma_in_valid),
        .in_ready_o (ma_in_ready),
        .in_data_i  (ma_in_data),
        .out_valid_o(ma_out_valid),
        .out_ready_i(ma_out_ready),
        .out_data_o (ma_out_data),
        .mem_req_o  (mem_req),
        .mem_rdata_i(mem_rdata)
    );

    pipe_reg #(.payload_t(wb_result_t)) u_out_reg (
        .clk        (clk),
        .rst        (rst),
        .in_valid_i (ma_out_valid),
        .in_ready_o (ma_out_ready),
        .in_data_i  (ma_out_data),
        .out_valid_o(out_valid_o),
        .out_ready_i(out_ready_i),
        .out_data_o (out_data_o)
    );

    byte_ram u_ram (
        .clk    (clk),
        .req_i  (mem_req),
        .rdata_o(mem_rdata)
    );

endmodule

// ==== src/mem_access.sv ====
`include "lsu_defs.svh"

module mem_access (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid_i,
    output logic                     in_ready_o,
    input  lsu_pkg::ex_result_t      in_data_i,
    output logic                     out_valid_o,
    input  logic                     out_ready_i,
    output lsu_pkg::wb_result_t      out_data_o,
    output membus_pkg::mem_bus_req_t mem_req_o,
    input  logic [`LSU_BYTE_W-1:0]   mem_rdata_i
);

    import lsu_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_write,
        st_read,
        st_drain, // last read byte in flight
        st_done   // result held until taken
    } state_e;

    state_e               state_q;
    logic [1:0]           idx_q;
    logic [1:0]           last_idx;
    ex_result_t           item_q;
    wb_result_t           res_q;
    logic [`LSU_XLEN-1:0] shift_q;
    logic [`LSU_XLEN-1:0] load_raw;
    logic [`LSU_XLEN-1:0] load_val;
    logic                 accept;
    logic                 take;

    assign take       = out_valid_o && out_ready_i;
    assign in_ready_o = (state_q == st_idle) || take;
    assign accept     = in_valid_i && in_ready_o;

    always_comb begin
        case (item_q.width)
            width_byte: last_idx = 2'd0;
            width_half: last_idx = 2'd1;
            default:    last_idx = 2'd3;
        endcase
    end

    // byte bus driven least significant byte first
    always_comb begin
        mem_req_o.en    = (state_q == st_write) || (state_q == st_read);
        mem_req_o.we    = (state_q == st_write);
        mem_req_o.addr  = item_q.addr + {{(`LSU_ADDR_W-2){1'b0}}, idx_q}; // wraps
        mem_req_o.wdata = item_q.wdata[{idx_q, 3'b000} +: `LSU_BYTE_W];
    end

    // returned bytes shift in at the top so the value lands in the upper bytes
    assign load_raw = {mem_rdata_i, shift_q[`LSU_XLEN-1:`LSU_BYTE_W]};

    always_comb begin
        case (item_q.width)
            width_byte: begin
                load_val = {{(`LSU_XLEN-8){item_q.load_signed & load_raw[`LSU_XLEN-1]}},
                            load_raw[`LSU_XLEN-1 -: 8]};
            end
            width_half: begin
                load_val = {{(`LSU_XLEN-16){item_q.load_signed & load_raw[`LSU_XLEN-1]}},
                            load_raw[`LSU_XLEN-1 -: 16]};
            end
            default: load_val = load_raw; // word as is
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_idle;
            idx_q   <= 2'd0;
        end else begin
            case (state_q)
                st_write: begin
                    idx_q <= idx_q + 2'd1;
                    if (idx_q == last_idx) begin
                        state_q <= st_done;
                    end
                end
                st_read: begin
                    idx_q <= idx_q + 2'd1;
                    if (idx_q == last_idx) begin
                        state_q <= st_drain;
                    end
                end
                st_drain: state_q <= st_done;
                default: begin // idle or done with the result leaving
                    if (accept) begin
                        idx_q <= 2'd0;
                        if (!in_data_i.is_mem) begin
                            state_q <= st_done;
                        end else if (in_data_i.is_store) begin
                            state_q <= st_write;
                        end else begin
                            state_q <= st_read;
                        end
                    end else if (take) begin
                        state_q <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            item_q <= in_data_i;
        end

        // idx 0 has no byte returned yet
        if (state_q == st_read && idx_q != 2'd0) begin
            shift_q <= load_raw;
        end

        if (accept && !in_data_i.is_mem) begin
            res_q.rd    <= in_data_i.rd;
            res_q.wdata <= in_data_i.wdata;
            res_q.wreg  <= in_data_i.wreg;
        end else if (state_q == st_write && idx_q == last_idx) begin
            res_q.rd    <= item_q.rd;
            res_q.wdata <= item_q.wdata;
            res_q.wreg  <= 1'b0; // stores write no register
        end else if (state_q == st_drain) begin
            res_q.rd    <= item_q.rd;
            res_q.wdata <= load_val;
            res_q.wreg  <= item_q.wreg;
        end
    end

    assign out_valid_o = (state_q == st_done);
    assign out_data_o  = res_q;

    // bus only busy for a latched load or store, in its own direction
    a_req_is_mem: assert property (@(posedge clk) disable iff (rst)
        mem_req_o.en |-> item_q.is_mem && (mem_req_o.we == item_q.is_store));

    a_width_legal: assert property (@(posedge clk) disable iff (rst)
        (state_q inside {st_write, st_read, st_drain})
        |-> (item_q.width inside {width_byte, width_half, width_word}));

    a_valid_held: assert property (@(posedge clk) disable iff (rst)
        out_valid_o && !out_ready_i |=> out_valid_o);

endmodule

// ==== src/membus_pkg.sv ====
`include "lsu_defs.svh"

package membus_pkg;

    // one byte per request, read data comes back a cycle later
    typedef struct packed {
        logic                   en;
        logic                   we;    // clear for a read
        logic [`LSU_ADDR_W-1:0] addr;
        logic [`LSU_BYTE_W-1:0] wdata;
    } mem_bus_req_t;

endpackage

// ==== src/pipe_reg.sv ====
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    logic     valid_q;
    payload_t data_q;

    // free slot, or the slot empties this cycle
    assign in_ready_o = !valid_q || out_ready_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

    // held output under back-pressure
    a_hold_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

// ==== verification/lsu_tb.sv ====
`include "lsu_defs.svh"

module lsu_tb;

    import lsu_pkg::*;

    logic       clk;
    logic       rst;
    logic       in_valid_i;
    logic       in_ready_o;
    ex_result_t in_data_i;
    logic       out_valid_o;
    logic       out_ready_i;
    wb_result_t out_data_o;

    logic [`LSU_BYTE_W-1:0] model_mem [`LSU_MEM_DEPTH];

    ex_result_t items_q[$];
    string      item_name_q[$];
    wb_result_t exp_q[$];
    string      exp_name_q[$];

    int   n_sent;
    int   n_recv;
    int   n_checks;
    int   n_errors;
    int   cycle_count;
    int   cycle_limit;
    logic bp_en; // random back-pressure on out_ready_i

    lsu_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .in_valid_i (in_valid_i),
        .in_ready_o (in_ready_o),
        .in_data_i  (in_data_i),
        .out_valid_o(out_valid_o),
        .out_ready_i(out_ready_i),
        .out_data_o (out_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // expected record for one item, memory model updated on stores
    function automatic wb_result_t ref_exec(input ex_result_t item);
        wb_result_t             res;
        logic [`LSU_XLEN-1:0]   val;
        logic [`LSU_ADDR_W-1:0] a;
        int                     nbytes;
        int                     i;
        res.rd    = item.rd;
        res.wdata = item.wdata;
        res.wreg  = item.wreg;
        if (item.is_mem) begin
            nbytes = (item.width == width_byte) ? 1 : (item.width == width_half) ? 2 : 4;
            val = '0;
            for (i = 0; i < nbytes; i++) begin
                a = item.addr + 16'(i); // wraps at the top
                if (item.is_store) begin
                    model_mem[a] = item.wdata[8*i +: 8];
                end else begin
                    val[8*i +: 8] = model_mem[a];
                end
            end
            if (item.is_store) begin
                res.wreg = 1'b0;
            end else begin
                if (item.load_signed && nbytes == 1 && val[7]) val[31:8] = '1;
                if (item.load_signed && nbytes == 2 && val[15]) val[31:16] = '1;
                res.wdata = val;
            end
        end
        return res;
    endfunction

    function automatic ex_result_t alu_item(input logic [4:0] rd, input logic [31:0] val,
                                            input logic wreg);
        ex_result_t it;
        it       = '0;
        it.rd    = rd;
        it.wdata = val;
        it.wreg  = wreg;
        return it;
    endfunction

    function automatic ex_result_t store_item(input logic [15:0] addr, input mem_width_e w,
                                              input logic [31:0] data);
        ex_result_t it;
        it          = '0;
        it.addr     = addr;
        it.wdata    = data;
        it.rd       = addr[4:0];
        it.wreg     = 1'b1; // must come back cleared
        it.is_mem   = 1'b1;
        it.is_store = 1'b1;
        it.width    = w;
        return it;
    endfunction

    function automatic ex_result_t load_item(input logic [4:0] rd, input logic [15:0] addr,
                                             input mem_width_e w, input logic sgn);
        ex_result_t it;
        it             = '0;
        it.rd          = rd;
        it.addr        = addr;
        it.wreg        = 1'b1;
        it.is_mem      = 1'b1;
        it.width       = w;
        it.load_signed = sgn;
        return it;
    endfunction

    task automatic enqueue(input string name, input ex_result_t it);
        items_q.push_back(it);
        item_name_q.push_back(name);
    endtask

    task automatic build_tests();
        ex_result_t  it;
        int          i;
        int          kind;
        mem_width_e  w;
        logic [15:0] addr;
        for (i = 0; i < 8; i++) begin
            enqueue("alu", alu_item(5'(i + 1), 32'h1000_0001 * (i + 3), i[0]));
        end
        enqueue("store_load", store_item(16'h0010, width_word, 32'hf1e2_83a4));
        enqueue("store_load", load_item(5'd1, 16'h0010, width_word, 1'b0));
        enqueue("store_load", load_item(5'd2, 16'h0010, width_half, 1'b1));
        enqueue("store_load", load_item(5'd3, 16'h0010, width_half, 1'b0));
        enqueue("store_load", load_item(5'd4, 16'h0012, width_half, 1'b1));
        enqueue("store_load", load_item(5'd5, 16'h0011, width_byte, 1'b1));
        enqueue("store_load", load_item(5'd6, 16'h0011, width_byte, 1'b0));
        enqueue("store_load", store_item(16'h0011, width_half, 32'h0000_7f05));
        enqueue("store_load", load_item(5'd7, 16'h0010, width_word, 1'b1));
        enqueue("store_load", load_item(5'd8, 16'h0012, width_byte, 1'b1));
        enqueue("store_load", store_item(16'h0013, width_byte, 32'h0000_0092));
        enqueue("store_load", load_item(5'd9, 16'h0012, width_half, 1'b1));
        enqueue("store_load", load_item(5'd10, 16'h0010, width_word, 1'b0));
        enqueue("unaligned", store_item(16'h0203, width_word, 32'h1234_5678));
        enqueue("unaligned", load_item(5'd11, 16'h0204, width_half, 1'b1));
        enqueue("unaligned", load_item(5'd12, 16'h0203, width_word, 1'b0));
        enqueue("unaligned", load_item(5'd13, 16'h0205, width_half, 1'b0));
        enqueue("wrap", store_item(16'hfffe, width_word, 32'hc0de_9a81));
        enqueue("wrap", load_item(5'd14, 16'hfffe, width_word, 1'b0));
        enqueue("wrap", load_item(5'd15, 16'hffff, width_half, 1'b1));
        enqueue("wrap", load_item(5'd16, 16'h0000, width_byte, 1'b1));
        enqueue("wrap", store_item(16'hffff, width_half, 32'h0000_55aa));
        enqueue("wrap", load_item(5'd17, 16'hfffe, width_word, 1'b1));
        // random loads only touch bytes written here
        for (i = 0; i < 16; i++) begin
            enqueue("prefill", store_item(16'h0100 + 16'(4 * i), width_word, $urandom));
        end
        for (i = 0; i < 160; i++) begin
            kind = $urandom % 3;
            w    = mem_width_e'($urandom % 3);
            addr = 16'h0100 + 16'($urandom % 60);
            case (kind)
                0:       it = alu_item(5'($urandom), $urandom, 1'($urandom));
                1:       it = store_item(addr, w, $urandom);
                default: it = load_item(5'($urandom), addr, w, 1'($urandom));
            endcase
            enqueue("random", it);
        end
    endtask

    task automatic send_item(input string name, input ex_result_t item);
        logic done;
        in_valid_i = 1'b1;
        in_data_i  = item;
        done       = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = in_ready_o;
            @(posedge clk);
            #1;
        end
        in_valid_i = 1'b0;
        exp_q.push_back(ref_exec(item));
        exp_name_q.push_back(name);
        n_sent++;
    endtask

    task automatic check_wb(input string test, input wb_result_t exp, input wb_result_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("error %s expected rd=%0d wdata=%h wreg=%b actual rd=%0d wdata=%h wreg=%b",
                     test, exp.rd, exp.wdata, exp.wreg, act.rd, act.wdata, act.wreg);
        end
    endtask

    task automatic check_idle();
        n_checks++;
        if (out_valid_o !== 1'b0) begin
            n_errors++;
            $display("out_valid_o is not low after reset");
        end
        if (in_ready_o !== 1'b1) begin
            n_errors++;
            $display("in_ready_o is not high after reset");
        end
    endtask

    // back-pressure, bp_en sampled on the edge before it can change
    initial begin
        logic en;
        forever begin
            @(posedge clk);
            en = bp_en;
            #1;
            out_ready_i = en ? 1'($urandom % 2) : 1'b1;
        end
    end

    // transfer happens on the next rising edge
    always @(negedge clk) begin
        if (!rst && out_valid_o && out_ready_i) begin
            n_recv++;
            if (exp_q.size() == 0) begin
                n_errors++;
                $display("a record for rd %0d came out with no item waiting for it",
                         out_data_o.rd);
            end else begin
                check_wb(exp_name_q.pop_front(), exp_q.pop_front(), out_data_o);
            end
        end
    end

    initial begin
        @(posedge clk);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        n_errors++;
        $display("timeout after %0d cycles with %0d of %0d records received",
                 cycle_count, n_recv, n_sent);
        $display("checks %0d errors %0d records %0d items %0d",
                 n_checks, n_errors, n_recv, n_sent);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h8db153ff));
        rst         = 1'b1;
        in_valid_i  = 1'b0;
        in_data_i   = '0;
        out_ready_i = 1'b1;
        bp_en       = 1'b0;
        n_sent      = 0;
        n_recv      = 0;
        n_checks    = 0;
        n_errors    = 0;
        cycle_count = 0;
        build_tests();
        cycle_limit = 4 * items_q.size() * 6 + 200;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_idle();
        @(posedge clk);
        #1;
        while (items_q.size() > 0) begin
            bp_en = (item_name_q[0] == "random");
            send_item(item_name_q.pop_front(), items_q.pop_front());
        end
        bp_en = 1'b0;
        while (n_recv < n_sent) @(posedge clk);
        repeat (10) @(posedge clk); // catch duplicates
        n_checks++;
        if (exp_q.size() != 0 || n_recv != n_sent) begin
            n_errors++;
            $display("%0d records came out for %0d items, %0d still expected",
                     n_recv, n_sent, exp_q.size());
        end
        $display("checks %0d errors %0d records %0d items %0d",
                 n_checks, n_errors, n_recv, n_sent);
        if (n_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
src/lsu_pkg.sv
src/membus_pkg.sv
src/pipe_reg.sv
src/mem_access.sv
src/byte_ram.sv
src/lsu_top.sv
verification/lsu_tb.sv
